// File: Makefile
VERILATOR  ?= verilator
TOP        ?= tb_id_stage
FILELIST   ?= tb.f
FLAGS      ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing --assert
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
PASS_MSG   := PASS: all tests

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(shell cat $(FILELIST)) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: id_decoder.sv
`timescale 1ns/1ps

module id_decoder (
  input  id_pkg::fetch_t    entry,
  input  id_pkg::word_t     rj_data,
  input  id_pkg::word_t     rkd_data,
  output id_pkg::reg_addr_t rj_addr,
  output id_pkg::reg_addr_t rkd_addr,
  output id_pkg::decoded_t  dec
);
  import id_pkg::*;

  instr_t     instr;
  logic [5:0] op_maj;
  logic [3:0] op_sub;
  logic [1:0] op_grp;
  logic [4:0] op_min;
  reg_addr_t  rd;
  reg_addr_t  rj;
  reg_addr_t  rk;

  logic rr_group;
  logic inst_add_w;
  logic inst_sub_w;
  logic inst_slt;
  logic inst_and;
  logic inst_or;
  logic inst_xor;
  logic inst_addi_w;
  logic inst_ld_w;
  logic inst_st_w;
  logic inst_beq;
  logic inst_bne;
  logic inst_b;
  logic inst_div_w;
  logic inst_rr;
  logic legal;
  logic src_is_rd;
  logic need_si12;
  logic need_si16;

  alu_op_t alu_op;
  word_t   imm;

  assign instr  = entry.instr;
  assign op_maj = instr[31:26];
  assign op_sub = instr[25:22];
  assign op_grp = instr[21:20];
  assign op_min = instr[19:15];
  assign rd     = instr[4:0];
  assign rj     = instr[9:5];
  assign rk     = instr[14:10];

  assign rr_group = (op_maj == OP_MAJ_ALU) && (op_sub == OP_SUB_RR) && (op_grp == OP_GRP_RR);

  assign inst_add_w  = rr_group && (op_min == OP_MIN_ADD);
  assign inst_sub_w  = rr_group && (op_min == OP_MIN_SUB);
  assign inst_slt    = rr_group && (op_min == OP_MIN_SLT);
  assign inst_and    = rr_group && (op_min == OP_MIN_AND);
  assign inst_or     = rr_group && (op_min == OP_MIN_OR);
  assign inst_xor    = rr_group && (op_min == OP_MIN_XOR);
  assign inst_div_w  = (op_maj == OP_MAJ_ALU) && (op_sub == OP_SUB_RR) &&
                       (op_grp == OP_GRP_DIV) && (op_min == OP_MIN_DIV);
  assign inst_addi_w = (op_maj == OP_MAJ_ALU) && (op_sub == OP_SUB_ADDI);
  assign inst_ld_w   = (op_maj == OP_MAJ_MEM) && (op_sub == OP_SUB_LDW);
  assign inst_st_w   = (op_maj == OP_MAJ_MEM) && (op_sub == OP_SUB_STW);
  assign inst_beq    = (op_maj == OP_MAJ_BEQ);
  assign inst_bne    = (op_maj == OP_MAJ_BNE);
  assign inst_b      = (op_maj == OP_MAJ_B);

  assign inst_rr = inst_add_w || inst_sub_w || inst_slt || inst_and || inst_or || inst_xor;
  assign legal   = inst_rr || inst_div_w || inst_addi_w || inst_ld_w || inst_st_w ||
                   inst_beq || inst_bne || inst_b;

  // stores and compares read rd as the second source
  assign src_is_rd = inst_st_w || inst_beq || inst_bne;
  assign rj_addr   = rj;
  assign rkd_addr  = src_is_rd ? rd : rk;

  assign need_si12 = inst_addi_w || inst_ld_w || inst_st_w;
  assign need_si16 = inst_beq || inst_bne;

  always_comb
  begin
    if (need_si12)
      imm = {{20{instr[21]}}, instr[21:10]};
    else if (need_si16)
      imm = {{16{instr[25]}}, instr[25:10]};
    else if (inst_b)
      imm = {{6{instr[9]}}, instr[9:0], instr[25:10]};
    else
      imm = '0;
  end

  always_comb
  begin
    alu_op = ALU_ADD;
    if (inst_sub_w || inst_beq || inst_bne)
      alu_op = ALU_SUB;
    else if (inst_slt)
      alu_op = ALU_SLT;
    else if (inst_and)
      alu_op = ALU_AND;
    else if (inst_or)
      alu_op = ALU_OR;
    else if (inst_xor)
      alu_op = ALU_XOR;
  end

  always_comb
  begin
    dec.pc        = entry.pc;
    dec.alu_op    = alu_op;
    dec.imm       = imm;
    dec.rj_addr   = rj_addr;
    dec.rkd_addr  = rkd_addr;
    dec.rj_value  = rj_data;
    dec.rkd_value = rkd_data;
    dec.dest      = rd;
    // an illegal encoding neither reads nor writes registers
    dec.gr_we     = legal && !(inst_st_w || inst_beq || inst_bne || inst_b);
    dec.use_rj    = legal && !inst_b;
    dec.use_rkd   = inst_rr || inst_div_w || inst_st_w || inst_beq || inst_bne;
    dec.is_load   = inst_ld_w;
    dec.is_store  = inst_st_w;
    dec.is_branch = inst_beq || inst_bne || inst_b;
    dec.is_div    = inst_div_w;
    dec.illegal   = !legal;
  end

endmodule

// File: id_pkg.sv
package id_pkg;

  typedef logic [31:0] word_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [2:0]  alu_op_t;

  localparam alu_op_t ALU_ADD = 3'd0;
  localparam alu_op_t ALU_SUB = 3'd1;
  localparam alu_op_t ALU_SLT = 3'd2;
  localparam alu_op_t ALU_AND = 3'd3;
  localparam alu_op_t ALU_OR  = 3'd4;
  localparam alu_op_t ALU_XOR = 3'd5;

  // major opcodes, bits 31..26
  localparam logic [5:0] OP_MAJ_ALU = 6'h00;
  localparam logic [5:0] OP_MAJ_MEM = 6'h0a;
  localparam logic [5:0] OP_MAJ_B   = 6'h14;
  localparam logic [5:0] OP_MAJ_BEQ = 6'h16;
  localparam logic [5:0] OP_MAJ_BNE = 6'h17;

  // bits 25..22
  localparam logic [3:0] OP_SUB_RR   = 4'h0;
  localparam logic [3:0] OP_SUB_ADDI = 4'ha;
  localparam logic [3:0] OP_SUB_LDW  = 4'h2;
  localparam logic [3:0] OP_SUB_STW  = 4'h6;

  // bits 21..20 select the three-register group
  localparam logic [1:0] OP_GRP_RR  = 2'd1;
  localparam logic [1:0] OP_GRP_DIV = 2'd2;

  // bits 19..15
  localparam logic [4:0] OP_MIN_ADD = 5'h00;
  localparam logic [4:0] OP_MIN_SUB = 5'h02;
  localparam logic [4:0] OP_MIN_SLT = 5'h04;
  localparam logic [4:0] OP_MIN_AND = 5'h09;
  localparam logic [4:0] OP_MIN_OR  = 5'h0a;
  localparam logic [4:0] OP_MIN_XOR = 5'h0b;
  localparam logic [4:0] OP_MIN_DIV = 5'h00;

  // one fetch queue entry
  typedef struct packed {
    word_t  pc;
    instr_t instr;
  } fetch_t;

  typedef struct packed {
    word_t     pc;
    alu_op_t   alu_op;
    word_t     imm;
    reg_addr_t rj_addr;
    reg_addr_t rkd_addr;
    word_t     rj_value;
    word_t     rkd_value;
    reg_addr_t dest;
    logic      gr_we;
    logic      use_rj;
    logic      use_rkd;
    logic      is_load;
    logic      is_store;
    logic      is_branch;
    logic      is_div;
    logic      illegal;
  } decoded_t;

endpackage

// File: id_stage.sv
`timescale 1ns/1ps

module id_stage (
  input  logic              clk,
  input  logic              rst,

  // fetch queue
  input  id_pkg::fetch_t    if_entry0,
  input  id_pkg::fetch_t    if_entry1,
  input  logic              if_valid0,
  input  logic              if_valid1,
  output logic [1:0]        if_pop,

  // register file, four read ports
  output id_pkg::reg_addr_t read_addr0,
  output id_pkg::reg_addr_t read_addr1,
  output id_pkg::reg_addr_t read_addr2,
  output id_pkg::reg_addr_t read_addr3,
  input  id_pkg::word_t     read_data0,
  input  id_pkg::word_t     read_data1,
  input  id_pkg::word_t     read_data2,
  input  id_pkg::word_t     read_data3,

  // execute
  input  logic              exe_ready,
  input  logic              flush,
  output id_pkg::decoded_t  exe_instr0,
  output id_pkg::decoded_t  exe_instr1,
  output logic              exe_valid0,
  output logic              exe_valid1
);
  import id_pkg::*;

  decoded_t dec0;
  decoded_t dec1;
  logic     issue_valid0;
  logic     issue_valid1;

  // slot 0 uses ports 0 and 1
  id_decoder dec_u0 (
    .entry    (if_entry0),
    .rj_data  (read_data0),
    .rkd_data (read_data1),
    .rj_addr  (read_addr0),
    .rkd_addr (read_addr1),
    .dec      (dec0)
  );

  // slot 1 uses ports 2 and 3
  id_decoder dec_u1 (
    .entry    (if_entry1),
    .rj_data  (read_data2),
    .rkd_data (read_data3),
    .rj_addr  (read_addr2),
    .rkd_addr (read_addr3),
    .dec      (dec1)
  );

  issue_pair_check pair_chk_u (
    .dec0         (dec0),
    .dec1         (dec1),
    .if_valid0    (if_valid0),
    .if_valid1    (if_valid1),
    .exe_ready    (exe_ready),
    .issue_valid0 (issue_valid0),
    .issue_valid1 (issue_valid1),
    .if_pop       (if_pop)
  );

  issue_reg issue_reg_u (
    .clk          (clk),
    .rst          (rst),
    .flush        (flush),
    .exe_ready    (exe_ready),
    .dec0         (dec0),
    .dec1         (dec1),
    .issue_valid0 (issue_valid0),
    .issue_valid1 (issue_valid1),
    .exe_instr0   (exe_instr0),
    .exe_instr1   (exe_instr1),
    .exe_valid0   (exe_valid0),
    .exe_valid1   (exe_valid1)
  );

endmodule

// File: id_stage_props.sv
`timescale 1ns/1ps

module id_stage_props (
  input logic             clk,
  input logic             rst,
  input logic             flush,
  input logic             exe_ready,
  input logic [1:0]       if_pop,
  input id_pkg::decoded_t exe_instr0,
  input id_pkg::decoded_t exe_instr1,
  input logic             exe_valid0,
  input logic             exe_valid1
);

  // nothing leaves fetch while execute stalls
  pop_needs_ready: assert property (@(posedge clk) disable iff (rst)
    !exe_ready |-> if_pop == 2'b00)
    else $error("if_pop nonzero while exe_ready is low");

  pop_in_order: assert property (@(posedge clk) disable iff (rst)
    if_pop[1] |-> if_pop[0])
    else $error("entry 1 popped without entry 0");

  clear_on_flush: assert property (@(posedge clk)
    (rst || flush) |=> !exe_valid0 && !exe_valid1)
    else $error("exe valids not cleared after flush or reset");

  hold_on_stall: assert property (@(posedge clk) disable iff (rst)
    (!exe_ready && !flush) |=> $stable(exe_instr0) && $stable(exe_instr1) &&
                               $stable({exe_valid0, exe_valid1}))
    else $error("issue register changed during a stall");

endmodule

bind id_stage id_stage_props props_u (
  .clk        (clk),
  .rst        (rst),
  .flush      (flush),
  .exe_ready  (exe_ready),
  .if_pop     (if_pop),
  .exe_instr0 (exe_instr0),
  .exe_instr1 (exe_instr1),
  .exe_valid0 (exe_valid0),
  .exe_valid1 (exe_valid1)
);

// File: issue_pair_check.sv
`timescale 1ns/1ps

module issue_pair_check (
  input  id_pkg::decoded_t dec0,
  input  id_pkg::decoded_t dec1,
  input  logic             if_valid0,
  input  logic             if_valid1,
  input  logic             exe_ready,
  output logic             issue_valid0,
  output logic             issue_valid1,
  output logic [1:0]       if_pop
);
  import id_pkg::*;

  logic mem0;
  logic mem1;
  logic writes_reg0;
  logic rj_hit;
  logic rkd_hit;
  logic branch_after_long;
  logic raw_hazard;
  logic both_mem;
  logic both_div;
  logic any_illegal;
  logic need_single;

  assign mem0 = dec0.is_load || dec0.is_store;
  assign mem1 = dec1.is_load || dec1.is_store;

  // r0 is hardwired to zero, so writing it never creates a dependency
  assign writes_reg0 = dec0.gr_we && (dec0.dest != reg_addr_t'(0));
  assign rj_hit      = dec1.use_rj && (dec1.rj_addr == dec0.dest);
  assign rkd_hit     = dec1.use_rkd && (dec1.rkd_addr == dec0.dest);
  assign raw_hazard  = writes_reg0 && (rj_hit || rkd_hit);

  assign branch_after_long = dec1.is_branch && (mem0 || dec0.is_div);
  assign both_mem          = mem0 && mem1;
  assign both_div          = dec0.is_div && dec1.is_div;
  assign any_illegal       = dec0.illegal || dec1.illegal;

  assign need_single = branch_after_long || raw_hazard || both_mem ||
                       both_div || any_illegal;

  assign issue_valid0 = if_valid0;
  assign issue_valid1 = if_valid1 && !need_single;

  // pop what execute accepts this cycle
  assign if_pop[0] = issue_valid0 && exe_ready;
  assign if_pop[1] = issue_valid1 && exe_ready;

endmodule

// File: issue_reg.sv
`timescale 1ns/1ps

module issue_reg (
  input  logic             clk,
  input  logic             rst,
  input  logic             flush,
  input  logic             exe_ready,
  input  id_pkg::decoded_t dec0,
  input  id_pkg::decoded_t dec1,
  input  logic             issue_valid0,
  input  logic             issue_valid1,
  output id_pkg::decoded_t exe_instr0,
  output id_pkg::decoded_t exe_instr1,
  output logic             exe_valid0,
  output logic             exe_valid1
);
  import id_pkg::*;

  decoded_t instr0_q;
  decoded_t instr1_q;
  logic     valid0_q;
  logic     valid1_q;

  always_ff @(posedge clk)
  begin
    if (rst || flush)
    begin
      instr0_q <= '0;
      instr1_q <= '0;
      valid0_q <= 1'b0;
      valid1_q <= 1'b0;
    end
    else if (exe_ready)
    begin
      instr0_q <= dec0;
      instr1_q <= dec1;
      valid0_q <= issue_valid0;
      valid1_q <= issue_valid1;
    end
    // otherwise hold while execute stalls
  end

  assign exe_instr0 = instr0_q;
  assign exe_instr1 = instr1_q;
  assign exe_valid0 = valid0_q;
  assign exe_valid1 = valid1_q;

endmodule

// File: tb.f
id_pkg.sv
id_decoder.sv
issue_pair_check.sv
issue_reg.sv
id_stage.sv
id_stage_props.sv
tb_id_stage.sv

// File: tb_id_stage.sv
`timescale 1ns/1ps

module tb_id_stage;
  import id_pkg::*;

  localparam int RST_CYCLES = 4;
  localparam int N_RAND     = 32;

  typedef struct {
    string      name;
    word_t      pc;
    instr_t     i0;
    instr_t     i1;
    logic [3:0] ctl;   // if_valid0 if_valid1 exe_ready flush
    logic [3:0] exp;   // if_pop[1:0] exe_valid0 exe_valid1
  } row_t;

  logic       clk = 1'b0;
  logic       rst;
  fetch_t     if_entry0;
  fetch_t     if_entry1;
  logic       if_valid0;
  logic       if_valid1;
  logic [1:0] if_pop;
  reg_addr_t  read_addr0;
  reg_addr_t  read_addr1;
  reg_addr_t  read_addr2;
  reg_addr_t  read_addr3;
  word_t      read_data0;
  word_t      read_data1;
  word_t      read_data2;
  word_t      read_data3;
  logic       exe_ready;
  logic       flush;
  decoded_t   exe_instr0;
  decoded_t   exe_instr1;
  logic       exe_valid0;
  logic       exe_valid1;

  row_t     tbl[$];
  // expected issue register contents after the last checked row
  decoded_t held0;
  decoded_t held1;
  int       errors      = 0;
  int       checks      = 0;
  int       cycles      = 0;
  int       cycle_limit = 1000;

  // add sub slt and or xor div addi ld st beq bne b, then xor/or reading r5, illegal
  instr_t enc_list [16] = '{
    32'h00100825, 32'h00111066, 32'h00120827, 32'h00148828,
    32'h00150829, 32'h0015882a, 32'h0020106b, 32'h02bff02c,
    32'h2880204d, 32'h2980406e, 32'h5bfff822, 32'h5c002064,
    32'h500043ff, 32'h00158ca6, 32'h00151448, 32'hffffffff
  };

  always #4 clk = ~clk;

  function automatic word_t rf_word(input reg_addr_t a);
    return {27'b0, a} * 32'h0101_0101;
  endfunction

  // register file model
  assign read_data0 = rf_word(read_addr0);
  assign read_data1 = rf_word(read_addr1);
  assign read_data2 = rf_word(read_addr2);
  assign read_data3 = rf_word(read_addr3);

  id_stage UUT (.*);

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // expected payload straight from the encoding rules
  function automatic decoded_t ref_decode(input word_t pc, input instr_t ins);
    decoded_t d;
    word_t    si12;
    d          = '0;
    si12       = {{20{ins[21]}}, ins[21:10]};
    d.pc       = pc;
    d.rj_addr  = ins[9:5];
    d.rkd_addr = ins[14:10];
    d.dest     = ins[4:0];
    d.illegal  = 1'b1;
    if (ins[31:20] == 12'h001 && ins[19:15] inside {5'h00, 5'h02, 5'h04, 5'h09, 5'h0a, 5'h0b})
    begin
      d.illegal = 1'b0;
      d.use_rkd = 1'b1;
      case (ins[19:15])
        5'h02:   d.alu_op = ALU_SUB;
        5'h04:   d.alu_op = ALU_SLT;
        5'h09:   d.alu_op = ALU_AND;
        5'h0a:   d.alu_op = ALU_OR;
        5'h0b:   d.alu_op = ALU_XOR;
        default: d.alu_op = ALU_ADD;
      endcase
    end
    else if (ins[31:15] == 17'h00040)
    begin
      d.illegal = 1'b0;
      d.is_div  = 1'b1;
      d.use_rkd = 1'b1;
    end
    else if (ins[31:22] inside {10'h00a, 10'h0a2, 10'h0a6})
    begin
      d.illegal  = 1'b0;
      d.imm      = si12;
      d.is_load  = ins[31:22] == 10'h0a2;
      d.is_store = ins[31:22] == 10'h0a6;
      d.use_rkd  = d.is_store;
      if (d.is_store)
        d.rkd_addr = ins[4:0];
    end
    else if (ins[31:27] == 5'b01011)
    begin
      // beq and bne compare rj with rd
      d.illegal   = 1'b0;
      d.is_branch = 1'b1;
      d.use_rkd   = 1'b1;
      d.rkd_addr  = ins[4:0];
      d.alu_op    = ALU_SUB;
      d.imm       = {{16{ins[25]}}, ins[25:10]};
    end
    else if (ins[31:26] == 6'h14)
    begin
      d.illegal   = 1'b0;
      d.is_branch = 1'b1;
      d.imm       = {{6{ins[9]}}, ins[9:0], ins[25:10]};
    end
    d.use_rj    = !d.illegal && !(ins[31:26] == 6'h14);
    d.gr_we     = !d.illegal && !d.is_store && !d.is_branch;
    d.rj_value  = rf_word(d.rj_addr);
    d.rkd_value = rf_word(d.rkd_addr);
    return d;
  endfunction

  function automatic logic must_wait(input decoded_t a, input decoded_t b);
    logic raw;
    logic mem_a;
    logic mem_b;
    mem_a = a.is_load || a.is_store;
    mem_b = b.is_load || b.is_store;
    raw   = a.gr_we && a.dest != 5'd0 &&
            ((b.use_rj && b.rj_addr == a.dest) || (b.use_rkd && b.rkd_addr == a.dest));
    return raw || (b.is_branch && (mem_a || a.is_div)) || (mem_a && mem_b) ||
           (a.is_div && b.is_div) || a.illegal || b.illegal;
  endfunction

  task automatic add_row(input string name, input instr_t i0, input instr_t i1,
                         input logic [3:0] ctl, input logic [3:0] exp);
    row_t r;
    r.name = name;
    r.pc   = 32'h1c00_0000 + 32'(tbl.size() * 8);
    r.i0   = i0;
    r.i1   = i1;
    r.ctl  = ctl;
    r.exp  = exp;
    tbl.push_back(r);
  endtask

  task automatic apply_row(input row_t r);
    if_entry0 <= {r.pc, r.i0};
    if_entry1 <= {r.pc + 32'd4, r.i1};
    if_valid0 <= r.ctl[3];
    if_valid1 <= r.ctl[2];
    exe_ready <= r.ctl[1];
    flush     <= r.ctl[0];
  endtask

  task automatic mismatch(input string name, input string what, input string exp,
                          input string act);
    errors++;
    $display("MISMATCH %s %s expected %s actual %s", name, what, exp, act);
  endtask

  task automatic check_pop(input row_t r);
    checks++;
    if (if_pop != r.exp[3:2])
      mismatch(r.name, "if_pop", $sformatf("%b", r.exp[3:2]), $sformatf("%b", if_pop));
  endtask

  task automatic check_exe(input row_t r);
    decoded_t exp0;
    decoded_t exp1;
    exp0 = ref_decode(r.pc, r.i0);
    exp1 = ref_decode(r.pc + 32'd4, r.i1);
    if (r.ctl[0])
    begin
      exp0 = '0;
      exp1 = '0;
    end
    else if (!r.ctl[1])
    begin
      exp0 = held0;
      exp1 = held1;
    end
    checks++;
    if ({exe_valid0, exe_valid1} != r.exp[1:0])
      mismatch(r.name, "exe valids", $sformatf("%b", r.exp[1:0]),
               $sformatf("%b%b", exe_valid0, exe_valid1));
    if (exe_instr0 != exp0)
      mismatch(r.name, "exe_instr0", $sformatf("%h", exp0), $sformatf("%h", exe_instr0));
    if (exe_instr1 != exp1)
      mismatch(r.name, "exe_instr1", $sformatf("%h", exp1), $sformatf("%h", exe_instr1));
    held0 = exp0;
    held1 = exp1;
  endtask

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles > cycle_limit)
    begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  initial
  begin
    logic [31:0] seed;
    logic        ns;
    rst       = 1'b1;
    if_entry0 = '0;
    if_entry1 = '0;
    if_valid0 = 1'b0;
    if_valid1 = 1'b0;
    exe_ready = 1'b0;
    flush     = 1'b0;
    seed      = 32'hc4b861bb;

    // each kept instruction alone in slot 0
    for (int k = 0; k < 13; k++)
      add_row($sformatf("decode_%0d", k), enc_list[k], 32'h0, 4'b1010, 4'b0110);
    add_row("pair_indep", 32'h00100825, 32'h00111066, 4'b1110, 4'b1111);
    add_row("raw_rj", 32'h00100825, 32'h00158ca6, 4'b1110, 4'b0110);
    add_row("raw_rkd", 32'h00100825, 32'h00151448, 4'b1110, 4'b0110);
    add_row("raw_store_data", 32'h00100825, 32'h29804065, 4'b1110, 4'b0110);
    add_row("two_mem", 32'h2880204d, 32'h2980406e, 4'b1110, 4'b0110);
    add_row("two_div", 32'h0020106b, 32'h0020082c, 4'b1110, 4'b0110);
    add_row("branch_after_load", 32'h2880204d, 32'h5bfff822, 4'b1110, 4'b0110);
    add_row("branch_after_div", 32'h0020106b, 32'h500043ff, 4'b1110, 4'b0110);
    add_row("illegal_slot0", 32'hffffffff, 32'h00111066, 4'b1110, 4'b0110);
    add_row("illegal_slot1", 32'h00100825, 32'hffffffff, 4'b1110, 4'b0110);
    add_row("r0_no_hazard", 32'h00100820, 32'h00100005, 4'b1110, 4'b1111);
    add_row("branch_after_alu", 32'h00100825, 32'h5c002064, 4'b1110, 4'b1111);
    add_row("load_after_alu", 32'h00100825, 32'h2880204d, 4'b1110, 4'b1111);
    add_row("no_valid", 32'h0, 32'h0, 4'b0010, 4'b0000);
    add_row("stall_load", 32'h00100825, 32'h00111066, 4'b1110, 4'b1111);
    for (int k = 1; k <= 3; k++)
      add_row($sformatf("stall_%0d", k), 32'h0015882a, 32'h00148828, 4'b1100, 4'b0011);
    add_row("stall_release", 32'h0015882a, 32'h00148828, 4'b1110, 4'b1111);
    add_row("flush_pulse", 32'h00100825, 32'h00111066, 4'b1111, 4'b1100);
    add_row("after_flush", 32'h2880204d, 32'h00111066, 4'b1110, 4'b1111);
    add_row("flush_in_stall", 32'h00100825, 32'h00111066, 4'b1101, 4'b0000);
    add_row("after_flush_stall", 32'h00100825, 32'hffffffff, 4'b1110, 4'b0110);

    for (int k = 0; k < N_RAND; k++)
    begin
      seed = xorshift(seed);
      ns   = must_wait(ref_decode(32'd0, enc_list[seed[3:0]]),
                       ref_decode(32'd0, enc_list[seed[7:4]]));
      add_row($sformatf("random_%0d", k), enc_list[seed[3:0]], enc_list[seed[7:4]],
              4'b1110, {!ns, 1'b1, 1'b1, !ns});
    end
    cycle_limit = tbl.size() + RST_CYCLES + 20;

    repeat (RST_CYCLES) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    checks++;
    if (exe_valid0 || exe_valid1)
      mismatch("reset", "exe valids", "00", $sformatf("%b%b", exe_valid0, exe_valid1));
    // reset clears the payload along with the valids
    held0 = '0;
    held1 = '0;

    // exe outputs of a row show up one edge after it is driven
    for (int k = 0; k <= tbl.size(); k++)
    begin
      @(posedge clk);
      if (k < tbl.size())
        apply_row(tbl[k]);
      @(negedge clk);
      if (k > 0)
        check_exe(tbl[k - 1]);
      if (k < tbl.size())
        check_pop(tbl[k]);
    end

    $display("checks: %0d  errors: %0d", checks, errors);
    if (errors == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule
